// File: ps_sys_top.f
sys_bus_pkg.sv
axi_burst_cnt.sv
axi_slave_fsm.sv
sys_bus_decoder.sv
sys_regs.sv
sys_bram.sv
ps_sys_top.sv
tb_ps_sys_top.sv

// File: tb_ps_sys_top.sv
/*
 * Testbench for ps_sys_top: transaction table applied through AXI
 * write and read tasks, shadow model of registers, LED and RAM,
 * typed compare tasks and a cycle watchdog
 */

`timescale 1ns/100ps

module tb_ps_sys_top;

  localparam int RESET_CYCLES = 4;
  localparam int MAX_ENTRIES  = 32;
  localparam int KIND_WR      = 0;
  localparam int KIND_RD      = 1;
  localparam int KIND_PAIR    = 2;

  logic                      clk;
  logic                      reset_i;
  logic                      awvalid, awready, wvalid, wlast, wready;
  logic                      bvalid, bready, arvalid, arready, rvalid, rlast, rready;
  sys_bus_pkg::addr_t        awaddr, araddr;
  sys_bus_pkg::id_t          awid, arid, bid, rid;
  sys_bus_pkg::len_t         awlen, arlen;
  sys_bus_pkg::data_t        wdata, rdata;
  sys_bus_pkg::strb_t        wstrb;
  sys_bus_pkg::resp_t        bresp, rresp;
  sys_bus_pkg::led_t         led_o;

  // Transaction table
  int                        n_entries;
  int                        tbl_kind  [MAX_ENTRIES];
  sys_bus_pkg::addr_t        tbl_addr  [MAX_ENTRIES];
  sys_bus_pkg::addr_t        tbl_raddr [MAX_ENTRIES];
  sys_bus_pkg::len_t         tbl_len   [MAX_ENTRIES];
  sys_bus_pkg::strb_t        tbl_strb  [MAX_ENTRIES];
  sys_bus_pkg::resp_t        tbl_resp  [MAX_ENTRIES];

  // Shadow state
  sys_bus_pkg::data_t        scr0_m, scr1_m;
  sys_bus_pkg::led_t         led_m;
  sys_bus_pkg::data_t        ram_m [256];
  logic                      last_rd_m;

  integer                    seed;
  int                        cycles, limit, beats;
  int                        aw_cycle, ar_cycle;
  int                        err_data, err_resp, err_id, err_led, err_flag, err_proto;
  sys_bus_pkg::id_t          cur_id;

  ps_sys_top #(.BRAM_AW (8)) dut_i (
    .clk (clk), .reset_i (reset_i),
    .awvalid_i (awvalid), .awaddr_i (awaddr), .awid_i (awid), .awlen_i (awlen),
    .awready_o (awready),
    .wvalid_i (wvalid), .wdata_i (wdata), .wstrb_i (wstrb), .wlast_i (wlast),
    .wready_o (wready),
    .bvalid_o (bvalid), .bid_o (bid), .bresp_o (bresp), .bready_i (bready),
    .arvalid_i (arvalid), .araddr_i (araddr), .arid_i (arid), .arlen_i (arlen),
    .arready_o (arready),
    .rvalid_o (rvalid), .rdata_o (rdata), .rid_o (rid), .rresp_o (rresp),
    .rlast_o (rlast), .rready_i (rready),
    .led_o (led_o)
  );

  always #10 clk = ~clk;

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_data(input string name, input sys_bus_pkg::data_t exp,
                            input sys_bus_pkg::data_t act);
    if (act !== exp) begin
      err_data++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input sys_bus_pkg::resp_t exp,
                            input sys_bus_pkg::resp_t act);
    if (act !== exp) begin
      err_resp++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_id(input string name, input sys_bus_pkg::id_t exp,
                          input sys_bus_pkg::id_t act);
    if (act !== exp) begin
      err_id++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_led(input string name, input sys_bus_pkg::led_t exp,
                           input sys_bus_pkg::led_t act);
    if (act !== exp) begin
      err_led++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_flag++;
      $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic sys_bus_pkg::data_t apply_strobes(input sys_bus_pkg::data_t old_w,
                                                       input sys_bus_pkg::data_t new_w,
                                                       input sys_bus_pkg::strb_t strb);
    sys_bus_pkg::data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  // Regions 0 and 1 only, reg offsets up to 0xC, RAM of 256 words
  function automatic logic beat_err(input sys_bus_pkg::addr_t a);
    if (a[15:12] == 4'd0) return (a[11:2] > 10'd3);
    if (a[15:12] == 4'd1) return (a[11:10] != 2'b00);
    return 1'b1;
  endfunction

  task automatic model_write(input sys_bus_pkg::addr_t a, input sys_bus_pkg::data_t d,
                             input sys_bus_pkg::strb_t s);
    if (!beat_err(a)) begin
      if (a[15:12] == 4'd1) begin
        ram_m[a[9:2]] = apply_strobes(ram_m[a[9:2]], d, s);
      end else begin
        case (a[3:2])
          2'd1: scr0_m = apply_strobes(scr0_m, d, s);
          2'd2: scr1_m = apply_strobes(scr1_m, d, s);
          2'd3: if (s[0]) led_m = d[7:0];
          default: ;
        endcase
      end
    end
  endtask

  function automatic sys_bus_pkg::data_t model_read(input sys_bus_pkg::addr_t a);
    if (beat_err(a)) return '0;
    if (a[15:12] == 4'd1) return ram_m[a[9:2]];
    case (a[3:2])
      2'd0:    return sys_bus_pkg::SYS_ID;
      2'd1:    return scr0_m;
      2'd2:    return scr1_m;
      default: return {24'h0, led_m};
    endcase
  endfunction

  //////////////////////////////
  // AXI transactions
  //////////////////////////////

  task automatic write_burst(input sys_bus_pkg::addr_t addr, input sys_bus_pkg::id_t id,
                             input sys_bus_pkg::len_t len, input sys_bus_pkg::strb_t strb,
                             input sys_bus_pkg::resp_t exp);
    sys_bus_pkg::addr_t a;
    sys_bus_pkg::data_t d;
    int                 dly;
    @(posedge clk);
    awvalid <= 1'b1;
    awaddr  <= addr;
    awid    <= id;
    awlen   <= len;
    @(negedge clk);
    while (!awready) @(negedge clk);
    aw_cycle  = cycles;
    last_rd_m = 1'b0;
    @(posedge clk);
    awvalid <= 1'b0;
    for (int i = 0; i <= len; i++) begin
      a = {addr[31:2], 2'b00} + i * 4;
      d = $random(seed);
      wvalid <= 1'b1;
      wdata  <= d;
      wstrb  <= strb;
      wlast  <= (i == len);
      @(negedge clk);
      while (!wready) @(negedge clk);
      @(posedge clk);
      model_write(a, d, strb);
    end
    wvalid <= 1'b0;
    wlast  <= 1'b0;
    // Response must hold while bready stays low
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    dly = $random(seed) & 3;
    for (int k = 0; k <= dly; k++) begin
      if (k > 0) @(negedge clk);
      check_flag("bvalid_o", 1'b1, bvalid);
      check_id("bid_o", id, bid);
      check_resp("bresp_o", exp, bresp);
    end
    @(posedge clk);
    bready <= 1'b1;
    @(negedge clk);
    check_flag("bvalid_o", 1'b1, bvalid);
    check_id("bid_o", id, bid);
    check_resp("bresp_o", exp, bresp);
    @(posedge clk);
    bready <= 1'b0;
    @(negedge clk);
    check_led("led_o", led_m, led_o);
  endtask

  task automatic check_rbeat(input sys_bus_pkg::data_t exp_d, input sys_bus_pkg::resp_t exp_r,
                             input sys_bus_pkg::id_t id, input logic is_last);
    check_flag("rvalid_o", 1'b1, rvalid);
    check_data("rdata_o", exp_d, rdata);
    check_resp("rresp_o", exp_r, rresp);
    check_id("rid_o", id, rid);
    if (is_last && (rlast !== 1'b1)) begin
      err_proto++;
      $display("at %0t: rlast is missing on the final beat of a read burst", $time);
    end else if (!is_last && (rlast !== 1'b0)) begin
      err_proto++;
      $display("at %0t: rlast is set before the final beat of a read burst", $time);
    end
  endtask

  task automatic read_burst(input sys_bus_pkg::addr_t addr, input sys_bus_pkg::id_t id,
                            input sys_bus_pkg::len_t len, input sys_bus_pkg::resp_t exp);
    sys_bus_pkg::addr_t a;
    sys_bus_pkg::data_t exp_d;
    int                 dly;
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= addr;
    arid    <= id;
    arlen   <= len;
    @(negedge clk);
    while (!arready) @(negedge clk);
    ar_cycle  = cycles;
    last_rd_m = 1'b1;
    @(posedge clk);
    arvalid <= 1'b0;
    for (int i = 0; i <= len; i++) begin
      a     = {addr[31:2], 2'b00} + i * 4;
      exp_d = model_read(a);
      @(negedge clk);
      while (!rvalid) @(negedge clk);
      dly = $random(seed) & 3;
      for (int k = 0; k <= dly; k++) begin
        if (k > 0) @(negedge clk);
        check_rbeat(exp_d, exp, id, i == len);
      end
      @(posedge clk);
      rready <= 1'b1;
      @(negedge clk);
      check_rbeat(exp_d, exp, id, i == len);
      @(posedge clk);
      rready <= 1'b0;
    end
  endtask

  // Write and read raised in the same cycle
  task automatic run_pair(input int n);
    logic             w_first;
    sys_bus_pkg::id_t wid;
    sys_bus_pkg::id_t rd_id;
    w_first = last_rd_m;
    wid     = 12'h300 + n[11:0];
    rd_id   = 12'h400 + n[11:0];
    fork
      write_burst(tbl_addr[n], wid, tbl_len[n], tbl_strb[n], tbl_resp[n]);
      read_burst(tbl_raddr[n], rd_id, tbl_len[n], tbl_resp[n]);
    join
    if (w_first && (ar_cycle < aw_cycle)) begin
      err_proto++;
      $display("at %0t: read was accepted first but the write channel had its turn", $time);
    end else if (!w_first && (aw_cycle < ar_cycle)) begin
      err_proto++;
      $display("at %0t: write was accepted first but the read channel had its turn", $time);
    end
  endtask

  task automatic add_entry(input int kind, input sys_bus_pkg::addr_t addr,
                           input sys_bus_pkg::len_t len, input sys_bus_pkg::strb_t strb,
                           input sys_bus_pkg::resp_t resp, input sys_bus_pkg::addr_t raddr);
    tbl_kind[n_entries]  = kind;
    tbl_addr[n_entries]  = addr;
    tbl_len[n_entries]   = len;
    tbl_strb[n_entries]  = strb;
    tbl_resp[n_entries]  = resp;
    tbl_raddr[n_entries] = raddr;
    n_entries++;
  endtask

  task automatic fill_table();
    // Register bank
    add_entry(KIND_RD, 32'h0000, 4'd0, 4'hF, sys_bus_pkg::RESP_OKAY, '0);
    add_entry(KIND_WR, 32'h0004, 4'd0, 4'hF, sys_bus_pkg::RESP_OKAY, '0);
    add_entry(KIND_WR, 32'h0004, 4'd0, 4'h6, sys_bus_pkg::RESP_OKAY, '0);
    add_entry(KIND_RD, 32'h0004, 4'd0, 4'hF, sys_bus_pkg::RESP_OKAY, '0);
    add_entry(KIND_WR, 32'h0008, 4'd0, 4'h9, sys_bus_pkg::RESP_OKAY, '0);
    add_entry(KIND_RD, 32'h0008, 4'd0, 4'hF, sys_bus_pkg::RESP_OKAY, '0);
    add_entry(KIND_WR, 32'h000C, 4'd0, 4'h1, sys_bus_pkg::RESP_OKAY, '0);
    add_entry(KIND_WR, 32'h000C, 4'd0, 4'hE, sys_bus_pkg::RESP_OKAY, '0);
    add_entry(KIND_RD, 32'h000C, 4'd0, 4'hF, sys_bus_pkg::RESP_OKAY, '0);
    add_entry(KIND_WR, 32'h0000, 4'd0, 4'hF, sys_bus_pkg::RESP_OKAY, '0);
    add_entry(KIND_RD, 32'h0000, 4'd0, 4'hF, sys_bus_pkg::RESP_OKAY, '0);
    // RAM bursts of 1, 4 and 16 beats
    add_entry(KIND_WR, 32'h1000, 4'd0,  4'hF, sys_bus_pkg::RESP_OKAY, '0);
    add_entry(KIND_WR, 32'h1010, 4'd3,  4'hF, sys_bus_pkg::RESP_OKAY, '0);
    add_entry(KIND_WR, 32'h1100, 4'd15, 4'hF, sys_bus_pkg::RESP_OKAY, '0);
    add_entry(KIND_RD, 32'h1000, 4'd0,  4'hF, sys_bus_pkg::RESP_OKAY, '0);
    add_entry(KIND_RD, 32'h1010, 4'd3,  4'hF, sys_bus_pkg::RESP_OKAY, '0);
    add_entry(KIND_RD, 32'h1100, 4'd15, 4'hF, sys_bus_pkg::RESP_OKAY, '0);
    add_entry(KIND_WR, 32'h1014, 4'd0,  4'h5, sys_bus_pkg::RESP_OKAY, '0);
    add_entry(KIND_RD, 32'h1010, 4'd3,  4'hF, sys_bus_pkg::RESP_OKAY, '0);
    // Error cases
    add_entry(KIND_WR, 32'h3000, 4'd0, 4'hF, sys_bus_pkg::RESP_SLVERR, '0);
    add_entry(KIND_RD, 32'h3000, 4'd1, 4'hF, sys_bus_pkg::RESP_SLVERR, '0);
    add_entry(KIND_WR, 32'h0010, 4'd0, 4'hF, sys_bus_pkg::RESP_SLVERR, '0);
    add_entry(KIND_RD, 32'h0020, 4'd0, 4'hF, sys_bus_pkg::RESP_SLVERR, '0);
    add_entry(KIND_WR, 32'h1400, 4'd0, 4'hF, sys_bus_pkg::RESP_SLVERR, '0);
    add_entry(KIND_RD, 32'h17FC, 4'd0, 4'hF, sys_bus_pkg::RESP_SLVERR, '0);
    // Two good beats then two past the RAM end
    add_entry(KIND_WR, 32'h13F8, 4'd3, 4'hF, sys_bus_pkg::RESP_SLVERR, '0);
    add_entry(KIND_RD, 32'h13F8, 4'd1, 4'hF, sys_bus_pkg::RESP_OKAY, '0);
    // Word 0 would be hit if a bad RAM address leaked through
    add_entry(KIND_RD, 32'h1000, 4'd0, 4'hF, sys_bus_pkg::RESP_OKAY, '0);
    // Simultaneous pairs with a write in between to turn the round robin
    add_entry(KIND_PAIR, 32'h1200, 4'd1, 4'hF, sys_bus_pkg::RESP_OKAY, 32'h1100);
    add_entry(KIND_WR,   32'h1204, 4'd0, 4'hF, sys_bus_pkg::RESP_OKAY, '0);
    add_entry(KIND_PAIR, 32'h1300, 4'd1, 4'hF, sys_bus_pkg::RESP_OKAY, 32'h1200);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    clk       = 1'b0;
    reset_i   = 1'b1;
    awvalid   = 1'b0;
    awaddr    = '0;
    awid      = '0;
    awlen     = '0;
    wvalid    = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wlast     = 1'b0;
    bready    = 1'b0;
    arvalid   = 1'b0;
    araddr    = '0;
    arid      = '0;
    arlen     = '0;
    rready    = 1'b0;
    seed      = 88;
    scr0_m    = '0;
    scr1_m    = '0;
    led_m     = '0;
    last_rd_m = 1'b1;
    n_entries = 0;
    fill_table();
    repeat (RESET_CYCLES) @(posedge clk);
    reset_i <= 1'b0;
    @(negedge clk);
    check_flag("awready_o", 1'b0, awready);
    check_flag("arready_o", 1'b0, arready);
    check_flag("wready_o", 1'b0, wready);
    check_flag("bvalid_o", 1'b0, bvalid);
    check_flag("rvalid_o", 1'b0, rvalid);
    check_led("led_o", '0, led_o);
    for (int n = 0; n < n_entries; n++) begin
      case (tbl_kind[n])
        KIND_WR: begin
          cur_id = 12'h100 + n[11:0];
          write_burst(tbl_addr[n], cur_id, tbl_len[n], tbl_strb[n], tbl_resp[n]);
        end
        KIND_RD: begin
          cur_id = 12'h200 + n[11:0];
          read_burst(tbl_addr[n], cur_id, tbl_len[n], tbl_resp[n]);
        end
        default: run_pair(n);
      endcase
    end
    repeat (2) @(posedge clk);
    $display("errors: data %0d resp %0d id %0d led %0d flag %0d protocol %0d",
             err_data, err_resp, err_id, err_led, err_flag, err_proto);
    if ((err_data + err_resp + err_id + err_led + err_flag + err_proto) == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog, 40 cycles per beat of the table plus reset
  initial begin
    cycles = 0;
    beats  = 0;
    @(posedge clk);
    for (int n = 0; n < n_entries; n++) begin
      beats += (tbl_kind[n] == KIND_PAIR ? 2 : 1) * (int'(tbl_len[n]) + 1);
    end
    limit = 40 * beats + RESET_CYCLES;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: ps_sys_top.sv
/*
 * Top level: AXI slave bridge, system bus decoder, register bank
 * and block RAM
 */

`timescale 1ns/100ps

module ps_sys_top #(
  parameter int BRAM_AW = 8
) (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               awvalid_i,
  input  sys_bus_pkg::addr_t awaddr_i,
  input  sys_bus_pkg::id_t   awid_i,
  input  sys_bus_pkg::len_t  awlen_i,
  output logic               awready_o,
  input  logic               wvalid_i,
  input  sys_bus_pkg::data_t wdata_i,
  input  sys_bus_pkg::strb_t wstrb_i,
  input  logic               wlast_i,
  output logic               wready_o,
  output logic               bvalid_o,
  output sys_bus_pkg::id_t   bid_o,
  output sys_bus_pkg::resp_t bresp_o,
  input  logic               bready_i,
  input  logic               arvalid_i,
  input  sys_bus_pkg::addr_t araddr_i,
  input  sys_bus_pkg::id_t   arid_i,
  input  sys_bus_pkg::len_t  arlen_i,
  output logic               arready_o,
  output logic               rvalid_o,
  output sys_bus_pkg::data_t rdata_o,
  output sys_bus_pkg::id_t   rid_o,
  output sys_bus_pkg::resp_t rresp_o,
  output logic               rlast_o,
  input  logic               rready_i,
  output sys_bus_pkg::led_t  led_o
);

  // System bus
  sys_bus_pkg::addr_t sys_addr;
  sys_bus_pkg::data_t sys_wdata;
  sys_bus_pkg::strb_t sys_sel;
  logic               sys_wen;
  logic               sys_ren;
  sys_bus_pkg::data_t sys_rdata;
  logic               sys_ack;
  logic               sys_err;

  // Peripheral side
  logic               regs_wen;
  logic               regs_ren;
  sys_bus_pkg::data_t regs_rdata;
  logic               regs_ack;
  logic               regs_err;
  logic               bram_wen;
  logic               bram_ren;
  sys_bus_pkg::data_t bram_rdata;
  logic               bram_ack;

  axi_slave_fsm axi_slave_i (
    .clk (clk), .reset_i (reset_i),
    .awvalid_i (awvalid_i), .awaddr_i (awaddr_i), .awid_i (awid_i),
    .awlen_i (awlen_i), .awready_o (awready_o),
    .wvalid_i (wvalid_i), .wdata_i (wdata_i), .wstrb_i (wstrb_i),
    .wlast_i (wlast_i), .wready_o (wready_o),
    .bvalid_o (bvalid_o), .bid_o (bid_o), .bresp_o (bresp_o), .bready_i (bready_i),
    .arvalid_i (arvalid_i), .araddr_i (araddr_i), .arid_i (arid_i),
    .arlen_i (arlen_i), .arready_o (arready_o),
    .rvalid_o (rvalid_o), .rdata_o (rdata_o), .rid_o (rid_o), .rresp_o (rresp_o),
    .rlast_o (rlast_o), .rready_i (rready_i),
    .sys_addr_o (sys_addr), .sys_wdata_o (sys_wdata), .sys_sel_o (sys_sel),
    .sys_wen_o (sys_wen), .sys_ren_o (sys_ren), .sys_rdata_i (sys_rdata),
    .sys_ack_i (sys_ack), .sys_err_i (sys_err)
  );

  sys_bus_decoder #(.BRAM_AW (BRAM_AW)) decoder_i (
    .clk (clk), .reset_i (reset_i),
    .sys_addr_i (sys_addr), .sys_wen_i (sys_wen), .sys_ren_i (sys_ren),
    .sys_rdata_o (sys_rdata), .sys_ack_o (sys_ack), .sys_err_o (sys_err),
    .regs_wen_o (regs_wen), .regs_ren_o (regs_ren), .regs_rdata_i (regs_rdata),
    .regs_ack_i (regs_ack), .regs_err_i (regs_err),
    .bram_wen_o (bram_wen), .bram_ren_o (bram_ren), .bram_rdata_i (bram_rdata),
    .bram_ack_i (bram_ack)
  );

  sys_regs regs_i (
    .clk (clk), .reset_i (reset_i),
    .addr_i (sys_addr), .wdata_i (sys_wdata), .sel_i (sys_sel),
    .wen_i (regs_wen), .ren_i (regs_ren),
    .rdata_o (regs_rdata), .ack_o (regs_ack), .err_o (regs_err), .led_o (led_o)
  );

  sys_bram #(.BRAM_AW (BRAM_AW)) bram_i (
    .clk (clk), .reset_i (reset_i),
    .addr_i (sys_addr), .wdata_i (sys_wdata), .sel_i (sys_sel),
    .wen_i (bram_wen), .ren_i (bram_ren),
    .rdata_o (bram_rdata), .ack_o (bram_ack)
  );

endmodule

// File: sys_bram.sv
/*
 * Word-wide block RAM with byte strobes, one-cycle write ack and
 * a twice-registered read
 */

`timescale 1ns/100ps

module sys_bram #(
  parameter int BRAM_AW = 8
) (
  input  logic               clk,
  input  logic               reset_i,
  input  sys_bus_pkg::addr_t addr_i,
  input  sys_bus_pkg::data_t wdata_i,
  input  sys_bus_pkg::strb_t sel_i,
  input  logic               wen_i,
  input  logic               ren_i,
  output sys_bus_pkg::data_t rdata_o,
  output logic               ack_o
);

  sys_bus_pkg::data_t mem [2**BRAM_AW];
  sys_bus_pkg::data_t rd_q;
  logic [BRAM_AW-1:0] idx;
  logic               wen_d1;
  logic               ren_d1;
  logic               ren_d2;

  assign idx = addr_i[BRAM_AW+1:2];

  // Array read, then output register
  always_ff @(posedge clk) begin
    if (wen_i) begin
      for (int b = 0; b < $bits(sys_bus_pkg::strb_t); b++) begin
        if (sel_i[b]) mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
    if (ren_i) rd_q <= mem[idx];
    if (ren_d1) rdata_o <= rd_q;
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wen_d1 <= 1'b0;
      ren_d1 <= 1'b0;
      ren_d2 <= 1'b0;
    end else begin
      wen_d1 <= wen_i;
      ren_d1 <= ren_i;
      ren_d2 <= ren_d1;
    end
  end

  assign ack_o = wen_d1 || ren_d2;

endmodule

// File: sys_regs.sv
/*
 * Register bank: read-only ID, two scratch registers and the LED
 * register, all answering one cycle after the strobe
 */

`timescale 1ns/100ps

module sys_regs (
  input  logic               clk,
  input  logic               reset_i,
  input  sys_bus_pkg::addr_t addr_i,
  input  sys_bus_pkg::data_t wdata_i,
  input  sys_bus_pkg::strb_t sel_i,
  input  logic               wen_i,
  input  logic               ren_i,
  output sys_bus_pkg::data_t rdata_o,
  output logic               ack_o,
  output logic               err_o,
  output sys_bus_pkg::led_t  led_o
);

  logic [11:0]        ofs;
  sys_bus_pkg::data_t scr0_q;
  sys_bus_pkg::data_t scr1_q;
  sys_bus_pkg::led_t  led_q;

  // Byte lanes with a set strobe take the new data
  function automatic sys_bus_pkg::data_t merge_bytes(input sys_bus_pkg::data_t old_w,
                                                     input sys_bus_pkg::data_t new_w,
                                                     input sys_bus_pkg::strb_t sel);
    sys_bus_pkg::data_t res;
    res = old_w;
    for (int b = 0; b < $bits(sys_bus_pkg::strb_t); b++) begin
      if (sel[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  assign ofs = {addr_i[11:2], 2'b00};

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_o  <= 1'b0;
      err_o  <= 1'b0;
      scr0_q <= '0;
      scr1_q <= '0;
      led_q  <= '0;
    end else begin
      ack_o <= wen_i || ren_i;
      err_o <= (wen_i || ren_i) && (ofs > sys_bus_pkg::REG_OFS_LED);
      // ID writes fall through silently
      if (wen_i) begin
        case (ofs)
          sys_bus_pkg::REG_OFS_SCR0: scr0_q <= merge_bytes(scr0_q, wdata_i, sel_i);
          sys_bus_pkg::REG_OFS_SCR1: scr1_q <= merge_bytes(scr1_q, wdata_i, sel_i);
          sys_bus_pkg::REG_OFS_LED:  if (sel_i[0]) led_q <= wdata_i[7:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ren_i) begin
      case (ofs)
        sys_bus_pkg::REG_OFS_ID:   rdata_o <= sys_bus_pkg::SYS_ID;
        sys_bus_pkg::REG_OFS_SCR0: rdata_o <= scr0_q;
        sys_bus_pkg::REG_OFS_SCR1: rdata_o <= scr1_q;
        sys_bus_pkg::REG_OFS_LED:  rdata_o <= sys_bus_pkg::data_t'(led_q);
        default:                   rdata_o <= '0;
      endcase
    end
  end

  assign led_o = led_q;

endmodule

// File: sys_bus_decoder.sv
/*
 * System bus decoder: region select, strobe routing to the register
 * bank and RAM, response mux and the error answer for bad addresses
 */

`timescale 1ns/100ps

module sys_bus_decoder #(
  parameter int BRAM_AW = 8
) (
  input  logic               clk,
  input  logic               reset_i,
  input  sys_bus_pkg::addr_t sys_addr_i,
  input  logic               sys_wen_i,
  input  logic               sys_ren_i,
  output sys_bus_pkg::data_t sys_rdata_o,
  output logic               sys_ack_o,
  output logic               sys_err_o,
  output logic               regs_wen_o,
  output logic               regs_ren_o,
  input  sys_bus_pkg::data_t regs_rdata_i,
  input  logic               regs_ack_i,
  input  logic               regs_err_i,
  output logic               bram_wen_o,
  output logic               bram_ren_o,
  input  sys_bus_pkg::data_t bram_rdata_i,
  input  logic               bram_ack_i
);

  localparam logic [1:0] TGT_REGS = 2'd0;
  localparam logic [1:0] TGT_BRAM = 2'd1;
  localparam logic [1:0] TGT_NONE = 2'd2;

  logic [1:0] tgt;
  logic [1:0] tgt_q;
  logic       bram_in_range;
  logic       err_ack_q;

  // Word index must fit the RAM
  assign bram_in_range = ((sys_addr_i[11:2] >> BRAM_AW) == '0);

  always_comb begin
    if (sys_addr_i[15:12] == sys_bus_pkg::REGION_REGS) tgt = TGT_REGS;
    else if ((sys_addr_i[15:12] == sys_bus_pkg::REGION_BRAM) && bram_in_range) tgt = TGT_BRAM;
    else tgt = TGT_NONE;
  end

  assign regs_wen_o = sys_wen_i && (tgt == TGT_REGS);
  assign regs_ren_o = sys_ren_i && (tgt == TGT_REGS);
  assign bram_wen_o = sys_wen_i && (tgt == TGT_BRAM);
  assign bram_ren_o = sys_ren_i && (tgt == TGT_BRAM);

  // Target of the open request, plus the local error ack
  always_ff @(posedge clk) begin
    if (reset_i) begin
      tgt_q     <= TGT_NONE;
      err_ack_q <= 1'b0;
    end else begin
      if (sys_wen_i || sys_ren_i) tgt_q <= tgt;
      err_ack_q <= (sys_wen_i || sys_ren_i) && (tgt == TGT_NONE);
    end
  end

  // Response follows the answering peripheral
  always_comb begin
    case (tgt_q)
      TGT_REGS: begin
        sys_ack_o   = regs_ack_i;
        sys_err_o   = regs_err_i;
        sys_rdata_o = regs_rdata_i;
      end
      TGT_BRAM: begin
        sys_ack_o   = bram_ack_i;
        sys_err_o   = 1'b0;
        sys_rdata_o = bram_rdata_i;
      end
      default: begin
        sys_ack_o   = err_ack_q;
        sys_err_o   = err_ack_q;
        sys_rdata_o = '0;
      end
    endcase
  end

endmodule

// File: axi_slave_fsm.sv
/*
 * AXI slave FSM: takes one INCR burst at a time from the write or
 * read channel (round robin) and runs it beat by beat on the system bus
 */

`timescale 1ns/100ps

module axi_slave_fsm (
  input  logic               clk,
  input  logic               reset_i,
  // Write address
  input  logic               awvalid_i,
  input  sys_bus_pkg::addr_t awaddr_i,
  input  sys_bus_pkg::id_t   awid_i,
  input  sys_bus_pkg::len_t  awlen_i,
  output logic               awready_o,
  // Write data
  input  logic               wvalid_i,
  input  sys_bus_pkg::data_t wdata_i,
  input  sys_bus_pkg::strb_t wstrb_i,
  input  logic               wlast_i,
  output logic               wready_o,
  // Write response
  output logic               bvalid_o,
  output sys_bus_pkg::id_t   bid_o,
  output sys_bus_pkg::resp_t bresp_o,
  input  logic               bready_i,
  // Read address
  input  logic               arvalid_i,
  input  sys_bus_pkg::addr_t araddr_i,
  input  sys_bus_pkg::id_t   arid_i,
  input  sys_bus_pkg::len_t  arlen_i,
  output logic               arready_o,
  // Read data
  output logic               rvalid_o,
  output sys_bus_pkg::data_t rdata_o,
  output sys_bus_pkg::id_t   rid_o,
  output sys_bus_pkg::resp_t rresp_o,
  output logic               rlast_o,
  input  logic               rready_i,
  // System bus
  output sys_bus_pkg::addr_t sys_addr_o,
  output sys_bus_pkg::data_t sys_wdata_o,
  output sys_bus_pkg::strb_t sys_sel_o,
  output logic               sys_wen_o,
  output logic               sys_ren_o,
  input  sys_bus_pkg::data_t sys_rdata_i,
  input  logic               sys_ack_i,
  input  logic               sys_err_i
);

  sys_bus_pkg::axi_state_t state_q;
  logic                    last_rd_q;
  logic                    pick_w;
  logic                    pick_r;
  logic                    err_q;
  logic                    rlast_q;
  logic                    wen_q;
  sys_bus_pkg::id_t        id_q;
  sys_bus_pkg::data_t      rdata_q;
  sys_bus_pkg::data_t      wdata_q;
  sys_bus_pkg::strb_t      wstrb_q;
  logic                    cnt_load;
  logic                    cnt_step;
  logic                    cnt_last;

  //////////////////////////////
  // Channel choice and address
  //////////////////////////////

  // Ties go to the channel not served last
  assign pick_w = awvalid_i && (!arvalid_i || last_rd_q);
  assign pick_r = arvalid_i && !pick_w;

  assign awready_o = (state_q == sys_bus_pkg::IDLE) && pick_w;
  assign arready_o = (state_q == sys_bus_pkg::IDLE) && pick_r;
  assign cnt_load  = awready_o || arready_o;
  assign cnt_step  = sys_ack_i &&
                     ((state_q == sys_bus_pkg::WACK) || (state_q == sys_bus_pkg::RACK));

  axi_burst_cnt burst_cnt_i (
    .clk          (clk),
    .reset_i      (reset_i),
    .load_i       (cnt_load),
    .start_addr_i (pick_w ? awaddr_i : araddr_i),
    .len_i        (pick_w ? awlen_i : arlen_i),
    .step_i       (cnt_step),
    .addr_o       (sys_addr_o),
    .last_o       (cnt_last)
  );

  //////////////////////////////
  // State machine
  //////////////////////////////

  // wlast_i is ignored, the counter ends the burst
  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q   <= sys_bus_pkg::IDLE;
      last_rd_q <= 1'b1;
      err_q     <= 1'b0;
      rlast_q   <= 1'b0;
      wen_q     <= 1'b0;
    end else begin
      wen_q <= 1'b0;
      case (state_q)
        sys_bus_pkg::IDLE: begin
          if (pick_w) begin
            state_q   <= sys_bus_pkg::WDATA;
            last_rd_q <= 1'b0;
            err_q     <= 1'b0;
          end else if (pick_r) begin
            state_q   <= sys_bus_pkg::RREQ;
            last_rd_q <= 1'b1;
            err_q     <= 1'b0;
          end
        end
        sys_bus_pkg::WDATA: begin
          if (wvalid_i) begin
            state_q <= sys_bus_pkg::WACK;
            wen_q   <= 1'b1;
          end
        end
        sys_bus_pkg::WACK: begin
          // Any bad beat taints the whole burst
          if (sys_ack_i) begin
            err_q   <= err_q | sys_err_i;
            state_q <= cnt_last ? sys_bus_pkg::BRESP : sys_bus_pkg::WDATA;
          end
        end
        sys_bus_pkg::BRESP: begin
          if (bready_i) state_q <= sys_bus_pkg::IDLE;
        end
        sys_bus_pkg::RREQ: state_q <= sys_bus_pkg::RACK;
        sys_bus_pkg::RACK: begin
          if (sys_ack_i) begin
            err_q   <= sys_err_i;
            rlast_q <= cnt_last;
            state_q <= sys_bus_pkg::RDATA;
          end
        end
        sys_bus_pkg::RDATA: begin
          if (rready_i) state_q <= rlast_q ? sys_bus_pkg::IDLE : sys_bus_pkg::RREQ;
        end
        default: state_q <= sys_bus_pkg::IDLE;
      endcase
    end
  end

  // Transaction ID and beat payload
  always_ff @(posedge clk) begin
    if (cnt_load) id_q <= pick_w ? awid_i : arid_i;
    if (wready_o && wvalid_i) begin
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
    end
    if ((state_q == sys_bus_pkg::RACK) && sys_ack_i) rdata_q <= sys_rdata_i;
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign wready_o    = (state_q == sys_bus_pkg::WDATA);
  assign sys_wen_o   = wen_q;
  assign sys_ren_o   = (state_q == sys_bus_pkg::RREQ);
  assign sys_wdata_o = wdata_q;
  assign sys_sel_o   = wstrb_q;

  assign bvalid_o = (state_q == sys_bus_pkg::BRESP);
  assign bid_o    = id_q;
  assign bresp_o  = err_q ? sys_bus_pkg::RESP_SLVERR : sys_bus_pkg::RESP_OKAY;

  assign rvalid_o = (state_q == sys_bus_pkg::RDATA);
  assign rdata_o  = rdata_q;
  assign rid_o    = id_q;
  assign rresp_o  = err_q ? sys_bus_pkg::RESP_SLVERR : sys_bus_pkg::RESP_OKAY;
  assign rlast_o  = rlast_q;

endmodule

// File: axi_burst_cnt.sv
/*
 * Beat counter for one INCR burst, with the word address of the
 * current beat and a flag for the final beat
 */

`timescale 1ns/100ps

module axi_burst_cnt (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               load_i,
  input  sys_bus_pkg::addr_t start_addr_i,
  input  sys_bus_pkg::len_t  len_i,
  input  logic               step_i,
  output sys_bus_pkg::addr_t addr_o,
  output logic               last_o
);

  sys_bus_pkg::addr_t addr_q;
  sys_bus_pkg::len_t  left_q;

  // Beats remaining after the current one
  always_ff @(posedge clk) begin
    if (reset_i) begin
      left_q <= '0;
    end else if (load_i) begin
      left_q <= len_i;
    end else if (step_i && (left_q != '0)) begin
      left_q <= left_q - 1'b1;
    end
  end

  // Word aligned beat address, 32-bit beats only
  always_ff @(posedge clk) begin
    if (load_i) begin
      addr_q <= {start_addr_i[31:2], 2'b00};
    end else if (step_i) begin
      addr_q <= addr_q + 32'd4;
    end
  end

  assign addr_o = addr_q;
  assign last_o = (left_q == '0);

endmodule

// File: sys_bus_pkg.sv
/*
 * System bus package: bus and AXI field widths, response codes,
 * region map, register offsets and the bridge FSM state type
 */

package sys_bus_pkg;

  // Field widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [11:0] id_t;
  typedef logic [3:0]  len_t;
  typedef logic [1:0]  resp_t;
  typedef logic [7:0]  led_t;

  // AXI responses in use
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Region number lives in address bits 15:12
  localparam logic [3:0] REGION_REGS = 4'd0;
  localparam logic [3:0] REGION_BRAM = 4'd1;

  // Register window
  localparam data_t       SYS_ID       = 32'h5359_5301;
  localparam logic [11:0] REG_OFS_ID   = 12'h000;
  localparam logic [11:0] REG_OFS_SCR0 = 12'h004;
  localparam logic [11:0] REG_OFS_SCR1 = 12'h008;
  localparam logic [11:0] REG_OFS_LED  = 12'h00C;

  typedef enum logic [2:0] {
    IDLE, WDATA, WACK, BRESP, RREQ, RACK, RDATA
  } axi_state_t;

endpackage
